//--- synth_lpf.f
logic/synth_lpf_pkg.sv
logic/midi_cc_decoder.sv
logic/lpf_coef_rom.sv
logic/mac_unit.sv
logic/biquad_sequencer.sv
logic/synth_lpf.sv
tb/synth_lpf_asserts.sv
tb/synth_lpf_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the synth_lpf testbench with Verilator and scans the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module synth_lpf_tb \
    -f synth_lpf.f -o synth_lpf_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/synth_lpf_sim > sim.log 2>&1 || echo "=== FAIL ===" >> sim.log
cat sim.log
grep -q "=== FAIL ===" sim.log && exit 1 || exit 0

//--- tb/synth_lpf_tb.sv
// Stimulus only; the bound checker judges data and timing, MIDI is sent while the filter is idle
`timescale 1ns/100ps

module synth_lpf_tb;

    logic                                      reset;          // Clock, as the DUT names it
    logic                                      clk;            // Async reset, active high
    logic                                      midi_rdy;
    synth_lpf_pkg::midi_cmd_e                  midi_cmd;
    logic [3:0]                                midi_ch_sysn;
    logic [6:0]                                midi_data0;
    logic [6:0]                                midi_data1;
    logic                                      sample_in_rdy;
    logic signed [synth_lpf_pkg::sample_w-1:0] sample_in;
    logic                                      sample_out_rdy;
    logic signed [synth_lpf_pkg::sample_w-1:0] sample_out;

    int         tb_errs;                           // Missing outputs
    bit         summary_done;                      // Closing line reached
    int         n;
    int         k;
    logic [6:0] cc_vals [4] = '{7'h05, 7'h33, 7'h6a, 7'h47};  // Index 0, 3, 6, 4

    synth_lpf dut_i (
        .reset          (reset),
        .clk            (clk),
        .midi_rdy       (midi_rdy),
        .midi_cmd       (midi_cmd),
        .midi_ch_sysn   (midi_ch_sysn),
        .midi_data0     (midi_data0),
        .midi_data1     (midi_data1),
        .sample_in_rdy  (sample_in_rdy),
        .sample_in      (sample_in),
        .sample_out_rdy (sample_out_rdy),
        .sample_out     (sample_out)
    );

    always #5 reset = ~reset;                      // 10 ns period

    // ----------------------------
    // Drive helpers
    // ----------------------------
    // Every helper starts and ends 1 ns after a rising edge
    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge reset);
            #1;
        end
    endtask

    task automatic send_midi(input synth_lpf_pkg::midi_cmd_e cmd, input logic [3:0] ch,
                             input logic [6:0] d0, input logic [6:0] d1);
        midi_rdy     = 1'b1;                       // One-cycle strobe
        midi_cmd     = cmd;
        midi_ch_sysn = ch;
        midi_data0   = d0;
        midi_data1   = d1;
        @(posedge reset);
        #1;
        midi_rdy = 1'b0;
    endtask

    task automatic set_cutoff(input logic [6:0] value);
        send_midi(synth_lpf_pkg::cmd_cc, synth_lpf_pkg::lpf_midi_channel,
                  synth_lpf_pkg::lpf_cutoff_cc, value);
    endtask

    task automatic pulse_sample(input logic signed [synth_lpf_pkg::sample_w-1:0] value);
        sample_in     = value;
        sample_in_rdy = 1'b1;
        @(posedge reset);
        #1;
        sample_in_rdy = 1'b0;
    endtask

    task automatic wait_output();
        int cycles;
        bit seen;
        cycles = 0;
        seen   = sample_out_rdy;                   // Strobe may already be up
        while (!seen && cycles < 20) begin
            @(posedge reset);
            #1;                                    // Outputs settled after the edge
            seen = sample_out_rdy;
            cycles++;
        end
        if (!seen) begin
            tb_errs++;
            $display("No sample_out_rdy within 20 cycles of a sample at %0t", $time);
        end
    endtask

    task automatic filter_sample(input logic signed [synth_lpf_pkg::sample_w-1:0] value);
        pulse_sample(value);
        wait_output();
        idle_cycles($urandom_range(4, 0));         // Spacing 10 to 14 cycles
    endtask

    function automatic logic signed [synth_lpf_pkg::sample_w-1:0] random_sample(input int shift);
        logic [31:0] r;
        r = $urandom;
        return $signed(r[synth_lpf_pkg::sample_w-1:0]) >>> shift;
    endfunction

    function automatic logic signed [synth_lpf_pkg::sample_w-1:0] full_scale(input bit neg);
        if (neg) begin
            return {1'b1, {(synth_lpf_pkg::sample_w-1){1'b0}}};
        end
        return {1'b0, {(synth_lpf_pkg::sample_w-1){1'b1}}};
    endfunction

    // ----------------------------
    // Test sequence
    // ----------------------------
    initial begin
        void'($urandom(32'h8d1a));                 // Single seed for the run
        reset         = 1'b0;
        clk           = 1'b1;
        midi_rdy      = 1'b0;
        midi_cmd      = synth_lpf_pkg::cmd_note_off;
        midi_ch_sysn  = '0;
        midi_data0    = '0;
        midi_data1    = '0;
        sample_in_rdy = 1'b0;
        sample_in     = '0;
        tb_errs       = 0;
        summary_done  = 1'b0;
        repeat (2) @(posedge reset);
        #1;
        clk = 1'b0;

        for (n = 0; n < 8; n++) filter_sample(random_sample(0));  // Pass-through at index 7

        for (k = 0; k < 4; k++) begin
            set_cutoff(cc_vals[k]);                // History carries across the change
            for (n = 0; n < 10; n++) filter_sample(random_sample(2));
        end

        // Traffic the decoder must ignore
        send_midi(synth_lpf_pkg::cmd_cc, 4'd3, synth_lpf_pkg::lpf_cutoff_cc, 7'h00);
        send_midi(synth_lpf_pkg::cmd_cc, synth_lpf_pkg::lpf_midi_channel, 7'd7, 7'h00);
        send_midi(synth_lpf_pkg::cmd_note_on, synth_lpf_pkg::lpf_midi_channel,
                  synth_lpf_pkg::lpf_cutoff_cc, 7'h00);
        for (n = 0; n < 8; n++) filter_sample(random_sample(1));

        for (n = 0; n < 6; n++) begin
            pulse_sample(random_sample(1));
            idle_cycles($urandom_range(8, 0));     // Second strobe lands while busy
            pulse_sample(random_sample(0));
            wait_output();
            idle_cycles(4);
        end

        set_cutoff(7'h0a);                         // Lowest cutoff
        for (n = 0; n < 24; n++) filter_sample(full_scale($urandom_range(1, 0) == 1));
        for (n = 0; n < 120; n++) filter_sample(full_scale(1'b1));  // Settles near low rail
        for (n = 0; n < 90; n++) filter_sample(full_scale(1'b0));   // Step overshoot clips
        repeat (20) @(posedge reset);

        summary_done = 1'b1;
        $display("Errors: %0d missing outputs, %0d assertion failures",
                 tb_errs, dut_i.asserts_i.assert_errs);
        if (tb_errs == 0 && dut_i.asserts_i.assert_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    final begin
        if (!summary_done) begin
            $display("=== FAIL ===");             // Run stopped early
        end
    end

endmodule

//--- tb/synth_lpf_asserts.sv
// Reference biquad and strobe checks; assumes cutoff CC messages arrive only while the DUT is idle
`timescale 1ns/100ps

module synth_lpf_asserts (
    input logic                                      reset,          // Clock
    input logic                                      clk,            // Async reset, active high
    input logic                                      midi_rdy,
    input synth_lpf_pkg::midi_cmd_e                  midi_cmd,
    input logic [3:0]                                midi_ch_sysn,
    input logic [6:0]                                midi_data0,
    input logic [6:0]                                midi_data1,
    input logic                                      sample_in_rdy,
    input logic signed [synth_lpf_pkg::sample_w-1:0] sample_in,
    input logic                                      sample_out_rdy,
    input logic signed [synth_lpf_pkg::sample_w-1:0] sample_out
);

    logic [2:0]                                m_idx;          // Model cutoff index
    logic signed [synth_lpf_pkg::sample_w-1:0] m_x;            // Sample in flight
    logic signed [synth_lpf_pkg::sample_w-1:0] m_x1;
    logic signed [synth_lpf_pkg::sample_w-1:0] m_x2;
    logic signed [synth_lpf_pkg::sample_w-1:0] m_y1;
    logic signed [synth_lpf_pkg::sample_w-1:0] m_y2;
    logic signed [synth_lpf_pkg::sample_w-1:0] exp_y;          // Expected next output
    logic [3:0]                                busy_cnt;       // Cycles left until the strobe
    logic                                      exp_rdy;
    int                                        assert_errs = 0;  // Read by the testbench

    // ----------------------------
    // Behavioral biquad
    // ----------------------------
    function automatic logic signed [synth_lpf_pkg::sample_w-1:0] biquad_step(
        input logic [2:0]                                idx,
        input logic signed [synth_lpf_pkg::sample_w-1:0] xn,
        input logic signed [synth_lpf_pkg::sample_w-1:0] xa,
        input logic signed [synth_lpf_pkg::sample_w-1:0] xb,
        input logic signed [synth_lpf_pkg::sample_w-1:0] ya,
        input logic signed [synth_lpf_pkg::sample_w-1:0] yb
    );
        longint sum;
        longint sat_max;
        sat_max = (longint'(1) <<< (synth_lpf_pkg::sample_w - 1)) - 1;
        sum = longint'(synth_lpf_pkg::lpf_coef(idx, synth_lpf_pkg::tap_b0)) * xn
            + longint'(synth_lpf_pkg::lpf_coef(idx, synth_lpf_pkg::tap_b1)) * xa
            + longint'(synth_lpf_pkg::lpf_coef(idx, synth_lpf_pkg::tap_b2)) * xb
            - longint'(synth_lpf_pkg::lpf_coef(idx, synth_lpf_pkg::tap_a1)) * ya
            - longint'(synth_lpf_pkg::lpf_coef(idx, synth_lpf_pkg::tap_a2)) * yb;
        sum = sum >>> synth_lpf_pkg::coef_frac;   // Q2.16 back to sample scale, floor
        if (sum > sat_max) begin
            sum = sat_max;                         // Clip high
        end else if (sum < -sat_max - 1) begin
            sum = -sat_max - 1;                    // Clip low
        end
        return sum[synth_lpf_pkg::sample_w-1:0];
    endfunction

    // ----------------------------
    // Model state
    // ----------------------------
    always @(posedge reset or posedge clk) begin
        if (clk) begin
            m_idx    <= synth_lpf_pkg::cutoff_reset_idx;
            m_x      <= '0;
            m_x1     <= '0;
            m_x2     <= '0;
            m_y1     <= '0;
            m_y2     <= '0;
            exp_y    <= '0;
            busy_cnt <= '0;
            exp_rdy  <= 1'b0;
        end else begin
            exp_rdy <= (busy_cnt == 4'd1);         // Strobe on the ninth edge
            if (midi_rdy && midi_cmd == synth_lpf_pkg::cmd_cc
                && midi_ch_sysn == synth_lpf_pkg::lpf_midi_channel
                && midi_data0 == synth_lpf_pkg::lpf_cutoff_cc) begin
                m_idx <= midi_data1[6:4];          // Top three bits of the CC value
            end
            if (busy_cnt == 4'd0 && sample_in_rdy) begin
                busy_cnt <= 4'd9;                  // Accepted only when idle
                m_x      <= sample_in;
                exp_y    <= biquad_step(m_idx, sample_in, m_x1, m_x2, m_y1, m_y2);
            end else if (busy_cnt != 4'd0) begin
                busy_cnt <= busy_cnt - 4'd1;
            end
            if (busy_cnt == 4'd1) begin
                m_x1 <= m_x;                       // History moves with the output
                m_x2 <= m_x1;
                m_y1 <= exp_y;
                m_y2 <= m_y1;
            end
        end
    end

    // ----------------------------
    // Checks
    // ----------------------------
    rdy_timing_a: assert property (@(posedge reset) disable iff (clk)
        sample_out_rdy == exp_rdy)
    else begin
        assert_errs++;
        $error("error %0t sample_out_rdy got %0b expected %0b",
               $time, $sampled(sample_out_rdy), $sampled(exp_rdy));
    end

    out_value_a: assert property (@(posedge reset) disable iff (clk)
        sample_out_rdy |-> sample_out == exp_y)
    else begin
        assert_errs++;
        $error("error %0t sample_out got %0d expected %0d",
               $time, $sampled(sample_out), $sampled(exp_y));
    end

    // Output only moves together with its strobe
    out_hold_a: assert property (@(posedge reset) disable iff (clk)
        !sample_out_rdy |-> $stable(sample_out))
    else begin
        assert_errs++;
        $error("sample_out changed at %0t without a sample_out_rdy pulse", $time);
    end

endmodule

bind synth_lpf synth_lpf_asserts asserts_i (
    .reset          (reset),
    .clk            (clk),
    .midi_rdy       (midi_rdy),
    .midi_cmd       (midi_cmd),
    .midi_ch_sysn   (midi_ch_sysn),
    .midi_data0     (midi_data0),
    .midi_data1     (midi_data1),
    .sample_in_rdy  (sample_in_rdy),
    .sample_in      (sample_in),
    .sample_out_rdy (sample_out_rdy),
    .sample_out     (sample_out)
);

//--- logic/synth_lpf.sv
// No handshake on either side; sample_out_rdy follows an accepted sample by exactly 9 clocks
`timescale 1ns/100ps

module synth_lpf (
    input  logic                                      reset,          // Clock
    input  logic                                      clk,            // Async reset
    input  logic                                      midi_rdy,
    input  synth_lpf_pkg::midi_cmd_e                  midi_cmd,
    input  logic [3:0]                                midi_ch_sysn,
    input  logic [6:0]                                midi_data0,
    input  logic [6:0]                                midi_data1,
    input  logic                                      sample_in_rdy,
    input  logic signed [synth_lpf_pkg::sample_w-1:0] sample_in,
    output logic                                      sample_out_rdy,
    output logic signed [synth_lpf_pkg::sample_w-1:0] sample_out
);

    logic [2:0]                                cutoff_idx;
    synth_lpf_pkg::tap_e                       tap_sel;
    logic signed [synth_lpf_pkg::coef_w-1:0]   coef;
    synth_lpf_pkg::mac_op_e                    mac_op;
    logic signed [synth_lpf_pkg::sample_w-1:0] mac_operand;
    logic signed [synth_lpf_pkg::acc_w-1:0]    acc;

    // ----------------------------
    // Control path
    // ----------------------------
    midi_cc_decoder decoder_i (
        .reset        (reset),
        .clk          (clk),
        .midi_rdy     (midi_rdy),
        .midi_cmd     (midi_cmd),
        .midi_ch_sysn (midi_ch_sysn),
        .midi_data0   (midi_data0),
        .midi_data1   (midi_data1),
        .cutoff_idx   (cutoff_idx)
    );

    lpf_coef_rom coef_rom_i (
        .reset      (reset),
        .clk        (clk),
        .cutoff_idx (cutoff_idx),
        .tap_sel    (tap_sel),
        .coef       (coef)
    );

    // ----------------------------
    // Arithmetic and sequencing
    // ----------------------------
    mac_unit mac_i (
        .reset   (reset),
        .clk     (clk),
        .op      (mac_op),
        .coef    (coef),
        .operand (mac_operand),
        .acc     (acc)
    );

    biquad_sequencer seq_i (
        .reset          (reset),
        .clk            (clk),
        .sample_in_rdy  (sample_in_rdy),
        .sample_in      (sample_in),
        .tap_sel        (tap_sel),
        .coef           (coef),
        .op             (mac_op),
        .operand        (mac_operand),
        .acc            (acc),
        .sample_out_rdy (sample_out_rdy),
        .sample_out     (sample_out)
    );

endmodule

//--- logic/biquad_sequencer.sv
// Direct-form-I biquad, one sample per 10 clocks at most; samples arriving while busy are dropped
`timescale 1ns/100ps

module biquad_sequencer (
    input  logic                                      reset,          // Clock
    input  logic                                      clk,            // Async reset
    input  logic                                      sample_in_rdy,
    input  logic signed [synth_lpf_pkg::sample_w-1:0] sample_in,
    output synth_lpf_pkg::tap_e                       tap_sel,        // To coef ROM
    input  logic signed [synth_lpf_pkg::coef_w-1:0]   coef,
    output synth_lpf_pkg::mac_op_e                    op,             // To MAC, meets coef
    output logic signed [synth_lpf_pkg::sample_w-1:0] operand,
    input  logic signed [synth_lpf_pkg::acc_w-1:0]    acc,
    output logic                                      sample_out_rdy,
    output logic signed [synth_lpf_pkg::sample_w-1:0] sample_out
);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_drain,
        st_done
    } state_e;

    state_e                                    state;
    logic [1:0]                                drain_cnt;    // Waits out the MAC pipe
    logic signed [synth_lpf_pkg::sample_w-1:0] x;            // Current input
    logic signed [synth_lpf_pkg::sample_w-1:0] x1;
    logic signed [synth_lpf_pkg::sample_w-1:0] x2;
    logic signed [synth_lpf_pkg::sample_w-1:0] y1;
    logic signed [synth_lpf_pkg::sample_w-1:0] y2;
    synth_lpf_pkg::mac_op_e                    tap_op;
    logic signed [synth_lpf_pkg::sample_w-1:0] tap_operand;
    logic signed [synth_lpf_pkg::acc_w-1:0]    acc_shift;
    logic                                      ovf_pos;
    logic                                      ovf_neg;
    logic signed [synth_lpf_pkg::sample_w-1:0] y_new;

    // ----------------------------
    // Control FSM
    // ----------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            state     <= st_idle;
            tap_sel   <= synth_lpf_pkg::tap_b0;
            drain_cnt <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (sample_in_rdy) begin
                        state   <= st_issue;
                        tap_sel <= synth_lpf_pkg::tap_b0;   // First tap next cycle
                    end
                end
                st_issue: begin
                    if (tap_sel == synth_lpf_pkg::tap_a2) begin
                        state     <= st_drain;
                        drain_cnt <= '0;
                    end else begin
                        tap_sel <= synth_lpf_pkg::tap_e'(tap_sel + 3'd1);
                    end
                end
                st_drain: begin
                    // ROM, operand, product and acc stages of the last tap
                    if (drain_cnt == 2'd2) begin
                        state <= st_done;
                    end else begin
                        drain_cnt <= drain_cnt + 2'd1;
                    end
                end
                st_done: state <= st_idle;          // acc is final here
                default: state <= st_idle;
            endcase
        end
    end

    // ----------------------------
    // Tap decode and MAC issue
    // ----------------------------
    always_comb begin
        case (tap_sel)
            synth_lpf_pkg::tap_b0: begin
                tap_op      = synth_lpf_pkg::mac_load;  // Starts a fresh sum
                tap_operand = x;
            end
            synth_lpf_pkg::tap_b1: begin
                tap_op      = synth_lpf_pkg::mac_add;
                tap_operand = x1;
            end
            synth_lpf_pkg::tap_b2: begin
                tap_op      = synth_lpf_pkg::mac_add;
                tap_operand = x2;
            end
            synth_lpf_pkg::tap_a1: begin
                tap_op      = synth_lpf_pkg::mac_sub;   // Feedback terms subtract
                tap_operand = y1;
            end
            synth_lpf_pkg::tap_a2: begin
                tap_op      = synth_lpf_pkg::mac_sub;
                tap_operand = y2;
            end
            default: begin
                tap_op      = synth_lpf_pkg::mac_nop;
                tap_operand = '0;
            end
        endcase
    end

    // One-cycle delay so op and operand arrive with the ROM output
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            op      <= synth_lpf_pkg::mac_nop;
            operand <= '0;
        end else if (state == st_issue) begin
            op      <= tap_op;
            operand <= tap_operand;
        end else begin
            op      <= synth_lpf_pkg::mac_nop;      // Keeps acc frozen
        end
    end

    // ----------------------------
    // Scaling and saturation
    // ----------------------------
    assign acc_shift = acc >>> synth_lpf_pkg::coef_frac;  // Drop Q16 fraction
    // Out of range when any bit above the sample sign differs from the acc sign
    assign ovf_pos = !acc_shift[synth_lpf_pkg::acc_w-1] &&
                     (acc_shift[synth_lpf_pkg::acc_w-2:synth_lpf_pkg::sample_w-1] != '0);
    assign ovf_neg = acc_shift[synth_lpf_pkg::acc_w-1] &&
                     (acc_shift[synth_lpf_pkg::acc_w-2:synth_lpf_pkg::sample_w-1] != '1);

    always_comb begin
        if (ovf_pos) begin
            y_new = {1'b0, {(synth_lpf_pkg::sample_w-1){1'b1}}};  // Positive full scale
        end else if (ovf_neg) begin
            y_new = {1'b1, {(synth_lpf_pkg::sample_w-1){1'b0}}};  // Negative full scale
        end else begin
            y_new = acc_shift[synth_lpf_pkg::sample_w-1:0];
        end
    end

    // ----------------------------
    // Delay line and output
    // ----------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            x              <= '0;
            x1             <= '0;
            x2             <= '0;
            y1             <= '0;
            y2             <= '0;
            sample_out     <= '0;
            sample_out_rdy <= 1'b0;
        end else begin
            sample_out_rdy <= 1'b0;                 // Single-cycle strobe
            if (state == st_idle && sample_in_rdy) begin
                x <= sample_in;                     // Only accepted samples land here
            end
            if (state == st_done) begin
                sample_out     <= y_new;
                sample_out_rdy <= 1'b1;
                x2             <= x1;
                x1             <= x;
                y2             <= y1;
                y1             <= y_new;            // Feedback uses the saturated value
            end
        end
    end

endmodule

//--- logic/mac_unit.sv
// Two register stages before acc; acc holds its value on mac_nop and is read two clocks late
`timescale 1ns/100ps

module mac_unit (
    input  logic                                      reset,    // Clock
    input  logic                                      clk,      // Async reset
    input  synth_lpf_pkg::mac_op_e                    op,
    input  logic signed [synth_lpf_pkg::coef_w-1:0]   coef,
    input  logic signed [synth_lpf_pkg::sample_w-1:0] operand,
    output logic signed [synth_lpf_pkg::acc_w-1:0]    acc
);

    synth_lpf_pkg::mac_op_e                    op_s1;       // Opcode beside operand regs
    synth_lpf_pkg::mac_op_e                    op_s2;       // Opcode beside product reg
    logic signed [synth_lpf_pkg::coef_w-1:0]   coef_s1;
    logic signed [synth_lpf_pkg::sample_w-1:0] operand_s1;
    logic signed [synth_lpf_pkg::prod_w-1:0]   prod_s2;
    logic signed [synth_lpf_pkg::acc_w-1:0]    prod_ext;

    // ----------------------------
    // Datapath registers
    // ----------------------------
    always_ff @(posedge reset) begin
        coef_s1    <= coef;                         // Stage 1, A and B regs
        operand_s1 <= operand;
        prod_s2    <= coef_s1 * operand_s1;         // Stage 2, M reg
    end

    // Sign extend the product into the accumulator width
    assign prod_ext = {{(synth_lpf_pkg::acc_w - synth_lpf_pkg::prod_w)
                         {prod_s2[synth_lpf_pkg::prod_w-1]}},
                       prod_s2};

    // ----------------------------
    // Opcode pipe and accumulator
    // ----------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            op_s1 <= synth_lpf_pkg::mac_nop;
            op_s2 <= synth_lpf_pkg::mac_nop;
            acc   <= '0;
        end else begin
            op_s1 <= op;
            op_s2 <= op_s1;                         // Travels with the product
            case (op_s2)
                synth_lpf_pkg::mac_load: acc <= prod_ext;
                synth_lpf_pkg::mac_add:  acc <= acc + prod_ext;
                synth_lpf_pkg::mac_sub:  acc <= acc - prod_ext;
                default:                 acc <= acc;    // Result parked for the reader
            endcase
        end
    end

endmodule

//--- logic/lpf_coef_rom.sv
// One-cycle registered lookup; coef follows tap_sel one clock later, even when unused
`timescale 1ns/100ps

module lpf_coef_rom (
    input  logic                                    reset,      // Clock
    input  logic                                    clk,        // Async reset
    input  logic [2:0]                              cutoff_idx, // Current cutoff step
    input  synth_lpf_pkg::tap_e                     tap_sel,    // Tap being issued
    output logic signed [synth_lpf_pkg::coef_w-1:0] coef        // Q2.16
);

    // ----------------------------
    // Table read
    // ----------------------------
    logic signed [synth_lpf_pkg::coef_w-1:0] coef_next;

    // Constant table, maps to LUTs or a small block ROM
    assign coef_next = synth_lpf_pkg::lpf_coef(cutoff_idx, tap_sel);

    // ----------------------------
    // Output register
    // ----------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            coef <= '0;
        end else begin
            coef <= coef_next;                      // Lines up with the delayed MAC op
        end
    end

endmodule

//--- logic/midi_cc_decoder.sv
// Expects MIDI fields already parsed and held valid with the one-cycle midi_rdy strobe
`timescale 1ns/100ps

module midi_cc_decoder (
    input  logic                     reset,         // Clock
    input  logic                     clk,           // Async reset, active high
    input  logic                     midi_rdy,
    input  synth_lpf_pkg::midi_cmd_e midi_cmd,
    input  logic [3:0]               midi_ch_sysn,
    input  logic [6:0]               midi_data0,    // Controller number
    input  logic [6:0]               midi_data1,    // Controller value
    output logic [2:0]               cutoff_idx
);

    // ----------------------------
    // Message match
    // ----------------------------
    logic is_cc;                                    // Control change strobe
    logic our_channel;
    logic our_ctrl;
    logic cutoff_hit;

    assign is_cc       = midi_rdy && (midi_cmd == synth_lpf_pkg::cmd_cc);
    assign our_channel = (midi_ch_sysn == synth_lpf_pkg::lpf_midi_channel);
    assign our_ctrl    = (midi_data0 == synth_lpf_pkg::lpf_cutoff_cc);
    assign cutoff_hit  = is_cc && our_channel && our_ctrl;

    // ----------------------------
    // Cutoff index register
    // ----------------------------
    always_ff @(posedge reset or posedge clk) begin
        if (clk) begin
            cutoff_idx <= synth_lpf_pkg::cutoff_reset_idx;  // Start fully open
        end else if (cutoff_hit) begin
            cutoff_idx <= midi_data1[6:4];          // 128 CC steps folded to 8
        end
    end

endmodule

//--- logic/synth_lpf_pkg.sv
// Shared widths, enums and the Q2.16 cutoff table; only eight cutoff steps and no resonance
package synth_lpf_pkg;

    // ----------------------------
    // Widths
    // ----------------------------
    localparam int sample_w  = 18;                  // Signed audio sample
    localparam int coef_w    = 18;                  // Q2.16, 1.0 = 65536
    localparam int prod_w    = coef_w + sample_w;   // Full multiplier result
    localparam int acc_w     = 48;                  // DSP style accumulator
    localparam int coef_frac = 16;                  // Fraction bits dropped from acc

    // ----------------------------
    // MIDI side
    // ----------------------------
    typedef enum logic [2:0] {
        cmd_note_off,
        cmd_note_on,
        cmd_poly_at,
        cmd_cc,
        cmd_prog,
        cmd_chan_at,
        cmd_bend,
        cmd_sys
    } midi_cmd_e;

    localparam logic [3:0] lpf_midi_channel = 4'd0;   // Channel 1 in user numbering
    localparam logic [6:0] lpf_cutoff_cc    = 7'd74;  // Standard brightness controller
    localparam logic [2:0] cutoff_reset_idx = 3'd7;   // Filter fully open

    // ----------------------------
    // Filter and MAC
    // ----------------------------
    typedef enum logic [2:0] {
        tap_b0,
        tap_b1,
        tap_b2,
        tap_a1,
        tap_a2
    } tap_e;                                          // Also the issue order

    typedef enum logic [1:0] {
        mac_nop,
        mac_load,
        mac_add,
        mac_sub
    } mac_op_e;

    // Rows are {b0, b1, a1, a2}; b2 equals b0 for every low-pass row
    // Each row sums to unity DC gain after quantization
    localparam logic signed [coef_w-1:0] lpf_tbl [0:7][0:3] = '{
        '{18'sd62,    18'sd124,   -18'sd125252, 18'sd59964},  // fc near 0.01 fs
        '{18'sd237,   18'sd476,   -18'sd119452, 18'sd54866},  // fc near 0.02 fs
        '{18'sd875,   18'sd1752,  -18'sd107968, 18'sd45934},  // fc near 0.04 fs
        '{18'sd2397,  18'sd4794,  -18'sd91154,  18'sd35206},  // fc near 0.07 fs
        '{18'sd5183,  18'sd10368, -18'sd69615,  18'sd24813},  // fc near 0.11 fs
        '{18'sd9524,  18'sd19048, -18'sd43976,  18'sd16536},  // fc near 0.16 fs
        '{18'sd16844, 18'sd33689, -18'sd9655,   18'sd11496},  // fc near 0.23 fs
        '{18'sd65536, 18'sd0,     18'sd0,       18'sd0}       // Pass-through
    };

    function automatic logic signed [coef_w-1:0] lpf_coef(
        input logic [2:0] idx,
        input tap_e       tap
    );
        logic signed [coef_w-1:0] c;
        case (tap)
            tap_b0,
            tap_b2:  c = lpf_tbl[idx][0];             // Symmetric feed-forward
            tap_b1:  c = lpf_tbl[idx][1];
            tap_a1:  c = lpf_tbl[idx][2];
            tap_a2:  c = lpf_tbl[idx][3];
            default: c = '0;                          // Unused tap codes
        endcase
        return c;
    endfunction

endpackage
